//--- sim.f
+incdir+include
rtl/core_pkg.sv
rtl/decoder.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/alu.sv
rtl/core.sv
dv/core_chk.sv
dv/core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module core_tb -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcore_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

//--- dv/core_tb.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module core_tb;
    import core_pkg::*;

    // 64-word ROM indexed by a 6-bit word offset
    localparam int romDepth      = 64;
    localparam int timeoutCycles = 200;
    localparam int drainCycles   = 8;

    logic  clk;
    logic  rstN;
    word_t instrAddr;
    word_t instrData;
    word_t prAddr;
    word_t prWd;
    logic  prWe;
    word_t prRd;

    word_t       rom [romDepth];
    word_t       romIdx;
    int          progLen;
    int          errorCount;
    logic [15:0] lfsrState = 16'd34;
    word_t       seenAddrs [$];
    word_t       seenData [$];
    word_t       wantAddrs [$];
    word_t       wantData [$];

    core uut (
        .clk      (clk),
        .rstN     (rstN),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .prAddr   (prAddr),
        .prWd     (prWd),
        .prWe     (prWe),
        .prRd     (prRd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction ROM returns no-ops outside the program
    always_comb begin
        romIdx    = (instrAddr - `CORE_RESET_PC) >> 2;
        instrData = (romIdx < romDepth) ? rom[romIdx[5:0]] : '0;
    end

    function automatic word_t fillWord(word_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    endfunction

    assign prRd = fillWord(prAddr);

    always @(negedge clk) begin
        if (prWe) begin
            seenAddrs.push_back(prAddr);
            seenData.push_back(prWd);
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic word_t randomBits(int n);
        word_t value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsrBit()};
        end
        return value;
    endfunction

    function automatic word_t rType(logic [5:0] fn, int rs, int rt, int rd, logic [4:0] sh);
        return {`CORE_OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), sh, fn};
    endfunction

    function automatic word_t iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t jType(int target);
        word_t addr;
        addr = `CORE_RESET_PC + 32'(4 * target);
        return {`CORE_OP_J, addr[27:2]};
    endfunction

    task automatic checkValue(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic emit(word_t instr);
        rom[6'(progLen)] = instr;
        progLen++;
    endtask

    task automatic loadConst(int r, word_t value);
        emit(iType(`CORE_OP_LUI, 0, r, value[31:16]));
        emit(iType(`CORE_OP_ORI, r, r, value[15:0]));
    endtask

    task automatic storeReg(int rt, logic [15:0] offset);
        emit(iType(`CORE_OP_SW, 0, rt, offset));
    endtask

    task automatic expectStore(word_t addr, word_t data);
        wantAddrs.push_back(addr);
        wantData.push_back(data);
    endtask

    // R-type into $3, then store $3
    task automatic storeOp(logic [5:0] fn, int rs, int rt, logic [4:0] sh,
                           logic [15:0] offset, word_t expected);
        emit(rType(fn, rs, rt, 3, sh));
        storeReg(3, offset);
        expectStore({16'h0000, offset}, expected);
    endtask

    // Core is held in reset while the ROM is rewritten
    task automatic newProgram();
        @(posedge clk);
        rstN <= 1'b0;
        for (int i = 0; i < romDepth; i++) begin
            rom[6'(i)] = '0;
        end
        progLen = 0;
        wantAddrs.delete();
        wantData.delete();
    endtask

    task automatic resetDut();
        rstN <= 1'b0;
        seenAddrs.delete();
        seenData.delete();
        repeat (10) @(posedge clk);
        checkValue("stores during reset", word_t'(seenAddrs.size()), '0);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("instrAddr", instrAddr, `CORE_RESET_PC);
    endtask

    task automatic waitStores();
        int waited;
        waited = 0;
        while (seenAddrs.size() < wantAddrs.size() && waited < timeoutCycles) begin
            @(posedge clk);
            waited++;
        end
        if (seenAddrs.size() < wantAddrs.size()) begin
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     waited, seenAddrs.size(), wantAddrs.size());
            errorCount++;
        end
        // Wrong-path stores would land within a few more cycles
        repeat (drainCycles) @(posedge clk);
    endtask

    task automatic checkStores();
        for (int i = 0; i < wantAddrs.size(); i++) begin
            if (i < seenAddrs.size()) begin
                checkValue("prAddr", seenAddrs[i], wantAddrs[i]);
                checkValue("prWd", seenData[i], wantData[i]);
            end else begin
                $display("store %0d to address %h never reached the bus", i, wantAddrs[i]);
                errorCount++;
            end
        end
        if (seenAddrs.size() > wantAddrs.size()) begin
            $display("%0d more stores on the bus than the program makes",
                     seenAddrs.size() - wantAddrs.size());
            errorCount++;
        end
    endtask

    task automatic runProgram();
        resetDut();
        waitStores();
        checkStores();
    endtask

    task automatic resetTest();
        newProgram();
        repeat (3) emit('0);
        emit(iType(`CORE_OP_ORI, 0, 1, 16'h55AA));
        storeReg(1, 16'h0100);
        expectStore(32'h0000_0100, 32'h0000_55AA);
        runProgram();
    endtask

    task automatic aluTest();
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        a  = randomBits(32);
        b  = randomBits(32);
        sh = 5'(randomBits(5));
        newProgram();
        loadConst(1, a);
        loadConst(2, b);
        storeReg(1, 16'h0100);
        expectStore(32'h0000_0100, a);
        storeOp(`CORE_FN_ADDU, 1, 2, 5'd0, 16'h0104, a + b);
        storeOp(`CORE_FN_SUBU, 1, 2, 5'd0, 16'h0108, a - b);
        storeOp(`CORE_FN_AND, 1, 2, 5'd0, 16'h010C, a & b);
        storeOp(`CORE_FN_OR, 1, 2, 5'd0, 16'h0110, a | b);
        storeOp(`CORE_FN_SLT, 1, 2, 5'd0, 16'h0114, word_t'($signed(a) < $signed(b)));
        storeOp(`CORE_FN_SLT, 2, 1, 5'd0, 16'h0118, word_t'($signed(b) < $signed(a)));
        storeOp(`CORE_FN_SLL, 0, 2, sh, 16'h011C, b << sh);
        runProgram();
    endtask

    task automatic forwardingTest();
        word_t a;
        word_t b;
        word_t r3;
        word_t r4;
        word_t r5;
        a = randomBits(32);
        b = randomBits(32);
        newProgram();
        loadConst(1, a);
        loadConst(2, b);
        emit(rType(`CORE_FN_ADDU, 1, 2, 3, 5'd0));
        emit(rType(`CORE_FN_SUBU, 3, 1, 4, 5'd0));
        emit(rType(`CORE_FN_ADDU, 3, 4, 5, 5'd0));
        emit(rType(`CORE_FN_SUBU, 5, 3, 3, 5'd0));
        emit(rType(`CORE_FN_ADDU, 3, 3, 4, 5'd0));
        storeReg(4, 16'h0140);
        storeReg(5, 16'h0144);
        storeReg(3, 16'h0148);
        r3 = a + b;
        r4 = r3 - a;
        r5 = r3 + r4;
        r3 = r5 - r3;
        r4 = r3 + r3;
        expectStore(32'h0000_0140, r4);
        expectStore(32'h0000_0144, r5);
        expectStore(32'h0000_0148, r3);
        runProgram();
    endtask

    task automatic loadUseTest();
        word_t       addend;
        logic [15:0] addrImm;
        logic [15:0] offset;
        word_t       loadAddr;
        addend = randomBits(32);
        newProgram();
        loadConst(5, addend);
        for (int k = 0; k < 3; k++) begin
            addrImm  = {14'(randomBits(14)), 2'b00};
            loadAddr = {{16{addrImm[15]}}, addrImm};
            offset   = 16'h0200 + 16'(4 * k);
            emit(iType(`CORE_OP_LW, 0, 1, addrImm));
            emit(rType(`CORE_FN_ADDU, 1, 5, 2, 5'd0));
            storeReg(2, offset);
            expectStore({16'h0000, offset}, fillWord(loadAddr) + addend);
        end
        runProgram();
    endtask

    task automatic branchTest();
        word_t v;
        word_t w;
        v = randomBits(32);
        w = randomBits(32);
        if (w == v) begin
            w = ~v;
        end
        newProgram();
        loadConst(1, v);
        loadConst(3, w);
        emit(rType(`CORE_FN_ADDU, 1, 0, 2, 5'd0));
        // Taken to index 9 while the producer of $2 is still in execute
        emit(iType(`CORE_OP_BEQ, 1, 2, 16'd3));
        storeReg(1, 16'h0300);
        storeReg(3, 16'h0304);
        storeReg(3, 16'h0308);
        storeReg(2, 16'h030C);
        // Not taken
        emit(iType(`CORE_OP_BEQ, 1, 3, 16'd2));
        storeReg(1, 16'h0310);
        storeReg(3, 16'h0314);
        emit(jType(16));
        storeReg(2, 16'h0318);
        storeReg(3, 16'h031C);
        emit(iType(`CORE_OP_ORI, 0, 0, 16'h1234));
        storeReg(0, 16'h0320);
        expectStore(32'h0000_0300, v);
        expectStore(32'h0000_030C, v);
        expectStore(32'h0000_0310, v);
        expectStore(32'h0000_0314, w);
        expectStore(32'h0000_0318, v);
        expectStore(32'h0000_0320, 32'h0000_0000);
        runProgram();
    endtask

    initial begin
        rstN       = 1'b0;
        errorCount = 0;
        progLen    = 0;
        resetTest();
        aluTest();
        forwardingTest();
        loadUseTest();
        branchTest();
        $display("Errors found: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/core_chk.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module core_chk (
    input logic            clk,
    input logic            rstN,
    input core_pkg::word_t instrAddr,
    input core_pkg::word_t prAddr,
    input logic            prWe
);
    import core_pkg::*;

    // Bus stays quiet through reset and the cycle after
    noStoreInReset: assert property (@(posedge clk) (!rstN || $past(!rstN)) |-> !prWe)
        else $error("store on the bus during or right after reset");

    storeAligned: assert property (@(posedge clk) disable iff (!rstN)
        prWe |-> prAddr[1:0] == 2'b00)
        else $error("store address %h is not word aligned", prAddr);

    fetchAligned: assert property (@(posedge clk) disable iff (!rstN)
        instrAddr[1:0] == 2'b00)
        else $error("fetch address %h is not word aligned", instrAddr);

    fetchFromResetPc: assert property (@(posedge clk) $rose(rstN) |-> instrAddr == `CORE_RESET_PC)
        else $error("first fetch after reset is from %h", instrAddr);

endmodule

bind core core_chk chk (
    .clk      (clk),
    .rstN     (rstN),
    .instrAddr(instrAddr),
    .prAddr   (prAddr),
    .prWe     (prWe)
);

//--- rtl/core.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module core (
    input  logic            clk,
    input  logic            rstN,
    output core_pkg::word_t instrAddr,
    input  core_pkg::word_t instrData,
    output core_pkg::word_t prAddr,
    output core_pkg::word_t prWd,
    output logic            prWe,
    input  core_pkg::word_t prRd
);
    import core_pkg::*;

    word_t      pcF;
    word_t      pcNext;
    word_t      instrD;
    word_t      pcD;
    word_t      pcPlus4D;
    ctrl_t      ctrlD;
    regAddr_t   rsD;
    regAddr_t   rtD;
    regAddr_t   rdD;
    word_t      immD;
    word_t      rfA;
    word_t      rfB;
    word_t      opAD;
    word_t      opBD;
    word_t      branchTarget;
    word_t      jumpTarget;
    logic       takeBranch;
    logic       stall;
    fwdSel_t    fwdAD;
    fwdSel_t    fwdBD;
    fwdSel_t    fwdAE;
    fwdSel_t    fwdBE;
    idEx_t      idEx;
    exMem_t     exMem;
    memWb_t     memWb;
    word_t      srcAE;
    word_t      rtValE;
    word_t      srcBE;
    word_t      aluResE;
    regAddr_t   dstE;
    logic [4:0] shamtE;
    word_t      wbData;

    function automatic word_t pickOperand(fwdSel_t sel, word_t regVal, word_t memVal,
                                          word_t wbVal);
        case (sel)
            `CORE_FWD_MEM: return memVal;
            `CORE_FWD_WB:  return wbVal;
            default:       return regVal;
        endcase
    endfunction

    // Fetch
    assign instrAddr = pcF;
    assign pcNext    = ctrlD.isJump ? jumpTarget :
                       takeBranch   ? branchTarget : pcF + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF <= `CORE_RESET_PC;
        end else if (!stall) begin
            pcF <= pcNext;
        end
    end

    // IF/ID holds while decode waits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD <= '0;
            pcD    <= '0;
        end else if (!stall) begin
            instrD <= instrData;
            pcD    <= pcF;
        end
    end

    // Decode
    assign rsD      = instrD[25:21];
    assign rtD      = instrD[20:16];
    assign rdD      = instrD[15:11];
    assign pcPlus4D = pcD + 32'd4;
    assign immD     = ctrlD.zeroExtend ? {16'h0000, instrD[15:0]} :
                                         {{16{instrD[15]}}, instrD[15:0]};

    decoder decodeUnit (
        .instr(instrD),
        .ctrl (ctrlD)
    );

    regFile regs (
        .clk      (clk),
        .rstN     (rstN),
        .readAddrA(rsD),
        .readAddrB(rtD),
        .writeEn  (memWb.regWrite),
        .writeAddr(memWb.dst),
        .writeData(wbData),
        .readDataA(rfA),
        .readDataB(rfB)
    );

    assign opAD = pickOperand(fwdAD, rfA, exMem.aluRes, wbData);
    assign opBD = pickOperand(fwdBD, rfB, exMem.aluRes, wbData);

    // Delay slot is already in fetch when the branch resolves
    assign takeBranch   = ctrlD.isBranch && (opAD == opBD);
    assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

    hazardUnit hazards (
        .rsD    (rsD),
        .rtD    (rtD),
        .branchD(ctrlD.isBranch),
        .idEx   (idEx),
        .exMem  (exMem),
        .memWb  (memWb),
        .fwdAD  (fwdAD),
        .fwdBD  (fwdBD),
        .fwdAE  (fwdAE),
        .fwdBE  (fwdBE),
        .stall  (stall)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (stall) begin
            idEx <= '0;
        end else begin
            idEx <= '{ctrl: ctrlD, pc: pcD, rs: rsD, rt: rtD, rd: rdD,
                      opA: opAD, opB: opBD, imm: immD, shamt: instrD[10:6]};
        end
    end

    // Execute
    assign srcAE  = pickOperand(fwdAE, idEx.opA, exMem.aluRes, wbData);
    assign rtValE = pickOperand(fwdBE, idEx.opB, exMem.aluRes, wbData);
    assign srcBE  = idEx.ctrl.aluSrcImm ? idEx.imm : rtValE;
    assign shamtE = idEx.ctrl.aluSrcShamt ? idEx.shamt : 5'd0;
    assign dstE   = idEx.ctrl.regDstRd ? idEx.rd : idEx.rt;

    alu aluUnit (
        .srcA  (srcAE),
        .srcB  (srcBE),
        .shamt (shamtE),
        .aluOp (idEx.ctrl.aluOp),
        .result(aluResE)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem <= '{regWrite: idEx.ctrl.regWrite, memToReg: idEx.ctrl.memToReg,
                       memWrite: idEx.ctrl.memWrite, dst: dstE,
                       aluRes: aluResE, storeData: rtValE};
        end
    end

    // Memory stage drives the bus directly
    assign prAddr = exMem.aluRes;
    assign prWd   = exMem.storeData;
    assign prWe   = exMem.memWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb <= '{regWrite: exMem.regWrite, memToReg: exMem.memToReg,
                       dst: exMem.dst, aluRes: exMem.aluRes, loadData: prRd};
        end
    end

    // Writeback
    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluRes;

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module alu (
    input  core_pkg::word_t  srcA,
    input  core_pkg::word_t  srcB,
    input  logic [4:0]       shamt,
    input  core_pkg::aluOp_t aluOp,
    output core_pkg::word_t  result
);
    import core_pkg::*;

    logic lessThan;

    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluOp)
            `CORE_ALU_ADD: result = srcA + srcB;
            `CORE_ALU_SUB: result = srcA - srcB;
            `CORE_ALU_AND: result = srcA & srcB;
            `CORE_ALU_OR:  result = srcA | srcB;
            `CORE_ALU_SLT: result = word_t'(lessThan);
            `CORE_ALU_SLL: result = srcB << shamt;
            // Immediate moves into the upper half
            `CORE_ALU_LUI: result = {srcB[15:0], 16'h0000};
            default:       result = '0;
        endcase
    end

endmodule

//--- rtl/hazardUnit.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module hazardUnit (
    input  core_pkg::regAddr_t rsD,
    input  core_pkg::regAddr_t rtD,
    input  logic              branchD,
    input  core_pkg::idEx_t    idEx,
    input  core_pkg::exMem_t   exMem,
    input  core_pkg::memWb_t   memWb,
    output core_pkg::fwdSel_t  fwdAD,
    output core_pkg::fwdSel_t  fwdBD,
    output core_pkg::fwdSel_t  fwdAE,
    output core_pkg::fwdSel_t  fwdBE,
    output logic              stall
);
    import core_pkg::*;

    regAddr_t dstE;
    logic     memAluRes;
    logic     loadUse;
    logic     branchOnE;
    logic     branchOnLoadM;

    function automatic logic hits(logic wr, regAddr_t dst, regAddr_t src);
        return wr && dst != '0 && dst == src;
    endfunction

    function automatic fwdSel_t pickExec(regAddr_t src);
        if (hits(exMem.regWrite, exMem.dst, src)) begin
            return `CORE_FWD_MEM;
        end
        if (hits(memWb.regWrite, memWb.dst, src)) begin
            return `CORE_FWD_WB;
        end
        return `CORE_FWD_REG;
    endfunction

    assign dstE = idEx.ctrl.regDstRd ? idEx.rd : idEx.rt;

    // Load data is not ready in memory stage yet
    assign memAluRes = exMem.regWrite && !exMem.memToReg;

    // Writeback into decode is covered by the register file bypass
    assign fwdAD = hits(memAluRes, exMem.dst, rsD) ? `CORE_FWD_MEM : `CORE_FWD_REG;
    assign fwdBD = hits(memAluRes, exMem.dst, rtD) ? `CORE_FWD_MEM : `CORE_FWD_REG;

    always_comb begin
        fwdAE = pickExec(idEx.rs);
        fwdBE = pickExec(idEx.rt);
    end

    assign loadUse = idEx.ctrl.memToReg &&
                     (hits(1'b1, dstE, rsD) || hits(1'b1, dstE, rtD));
    assign branchOnE = branchD &&
                       (hits(idEx.ctrl.regWrite, dstE, rsD) ||
                        hits(idEx.ctrl.regWrite, dstE, rtD));
    // Second cycle of a branch waiting on a load
    assign branchOnLoadM = branchD && exMem.memToReg &&
                           (hits(exMem.regWrite, exMem.dst, rsD) ||
                            hits(exMem.regWrite, exMem.dst, rtD));

    assign stall = loadUse || branchOnE || branchOnLoadM;

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  core_pkg::regAddr_t readAddrA,
    input  core_pkg::regAddr_t readAddrB,
    input  logic              writeEn,
    input  core_pkg::regAddr_t writeAddr,
    input  core_pkg::word_t    writeData,
    output core_pkg::word_t    readDataA,
    output core_pkg::word_t    readDataB
);
    import core_pkg::*;

    // $0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write shows through to the reader
    assign readDataA = (readAddrA == '0) ? '0 :
                       (writeEn && readAddrA == writeAddr) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 :
                       (writeEn && readAddrB == writeAddr) ? writeData : regs[readAddrB];

endmodule

//--- rtl/decoder.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module decoder (
    input  core_pkg::word_t instr,
    output core_pkg::ctrl_t ctrl
);
    import core_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // Unknown encodings fall through as a no-op
        ctrl = ctrl_t'('0);
        ctrl.aluOp = `CORE_ALU_ADD;
        case (opcode)
            `CORE_OP_RTYPE: begin
                ctrl.regDstRd = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    `CORE_FN_ADDU: begin
                        ctrl.aluOp = `CORE_ALU_ADD;
                    end
                    `CORE_FN_SUBU: begin
                        ctrl.aluOp = `CORE_ALU_SUB;
                    end
                    `CORE_FN_AND: begin
                        ctrl.aluOp = `CORE_ALU_AND;
                    end
                    `CORE_FN_OR: begin
                        ctrl.aluOp = `CORE_ALU_OR;
                    end
                    `CORE_FN_SLT: begin
                        ctrl.aluOp = `CORE_ALU_SLT;
                    end
                    `CORE_FN_SLL: begin
                        ctrl.aluOp       = `CORE_ALU_SLL;
                        ctrl.aluSrcShamt = 1'b1;
                    end
                    default: begin
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
            `CORE_OP_ORI: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.zeroExtend = 1'b1;
                ctrl.aluOp      = `CORE_ALU_OR;
            end
            `CORE_OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = `CORE_ALU_LUI;
            end
            `CORE_OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `CORE_OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `CORE_OP_BEQ: begin
                ctrl.isBranch = 1'b1;
            end
            `CORE_OP_J: begin
                ctrl.isJump = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- rtl/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_WORD_W-1:0]     word_t;
    typedef logic [`CORE_REG_ADDR_W-1:0] regAddr_t;
    typedef logic [`CORE_ALU_OP_W-1:0]   aluOp_t;
    typedef logic [1:0]                  fwdSel_t;

    // Decode-stage control
    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memWrite;
        logic   aluSrcImm;
        logic   aluSrcShamt;
        logic   regDstRd;
        logic   zeroExtend;
        logic   isBranch;
        logic   isJump;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        ctrl_t      ctrl;
        word_t      pc;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        word_t      opA;
        word_t      opB;
        word_t      imm;
        logic [4:0] shamt;
    } idEx_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        logic     memWrite;
        regAddr_t dst;
        word_t    aluRes;
        word_t    storeData;
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        regAddr_t dst;
        word_t    aluRes;
        word_t    loadData;
    } memWb_t;

endpackage

//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath widths
`define CORE_WORD_W         32
`define CORE_REG_ADDR_W     5
`define CORE_ALU_OP_W       4

`define CORE_RESET_PC       32'h0000_3000

// Primary opcodes in instr[31:26]
`define CORE_OP_RTYPE       6'h00
`define CORE_OP_J           6'h02
`define CORE_OP_BEQ         6'h04
`define CORE_OP_ORI         6'h0d
`define CORE_OP_LUI         6'h0f
`define CORE_OP_LW          6'h23
`define CORE_OP_SW          6'h2b

// R-type function codes in instr[5:0]
`define CORE_FN_SLL         6'h00
`define CORE_FN_ADDU        6'h21
`define CORE_FN_SUBU        6'h23
`define CORE_FN_AND         6'h24
`define CORE_FN_OR          6'h25
`define CORE_FN_SLT         6'h2a

// ALU operations
`define CORE_ALU_ADD        4'd0
`define CORE_ALU_SUB        4'd1
`define CORE_ALU_AND        4'd2
`define CORE_ALU_OR         4'd3
`define CORE_ALU_SLT        4'd4
`define CORE_ALU_SLL        4'd5
`define CORE_ALU_LUI        4'd6

// Operand forwarding selects
`define CORE_FWD_REG        2'd0
`define CORE_FWD_MEM        2'd1
`define CORE_FWD_WB         2'd2

`endif
